//--- Makefile
TOP := tb_ul_package_data

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+hw
hw/ul_pack_pkg.sv
hw/ul_packet_capture.sv
hw/ul_sample_buffer.sv
hw/ul_read_sequencer.sv
hw/ul_sample_repack.sv
hw/ul_frame_assemble.sv
hw/ul_package_data.sv
sim/tb_ul_package_data.sv

//--- hw/ul_frame_assemble.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module ul_frame_assemble
    import ul_pack_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  rd_beat_t              i_beat,
    input  logic [`UL_WORD_W-1:0] i_packed,
    input  pkt_info_t             i_info,
    output cpri_wr_t              o_wr
);

    localparam int WORDS_PER_GROUP = `UL_GROUP_BEATS - 1;

    ctrl_kind_e            kind;
    logic [`UL_WORD_W-1:0] ctrl_word;
    logic [`UL_ADDR_W-1:0] ctrl_addr;
    logic [`UL_ADDR_W-1:0] data_addr;
    logic                  wen_q;
    logic                  last_q;
    logic [`UL_ADDR_W-1:0] addr_q;
    logic [`UL_WORD_W-1:0] data_q;

    // --------------------------------------------------
    // control word of each group
    // --------------------------------------------------
    always_comb
    begin
        if (i_beat.group == 4'd0)
            kind = CTRL_HDR;
        else if (i_beat.group <= 4'(`UL_NUM_ANT))
            kind = CTRL_POWER;
        else if (i_beat.group == 4'(`UL_NUM_GROUPS - 1))
            kind = CTRL_END;
        else
            kind = CTRL_RESERVED;
    end

    always_comb
    begin
        case (kind)
            CTRL_HDR:      ctrl_word = `UL_WORD_W'(i_info.hdr);
            CTRL_POWER:    ctrl_word = i_info.power[2'(i_beat.group - 4'd1)];
            CTRL_END:      ctrl_word = `UL_WORD_W'(`UL_END_MARK);
            default:       ctrl_word = '0;
        endcase
    end

    // first groups at the head slots, the rest at the tail
    assign ctrl_addr = (i_beat.group < 4'(`UL_DATA_BASE))
                     ? `UL_ADDR_W'(i_beat.group)
                     : `UL_ADDR_W'(`UL_TAIL_BASE + i_beat.group - `UL_DATA_BASE);

    assign data_addr = `UL_ADDR_W'(`UL_DATA_BASE + WORDS_PER_GROUP * i_beat.group
                                   + i_beat.beat - 1);

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wen_q  <= 1'b0;
            last_q <= 1'b0;
        end
        else
        begin
            wen_q  <= i_beat.vld;
            last_q <= i_beat.vld && i_beat.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_beat.beat == 3'd0)
        begin
            addr_q <= ctrl_addr;
            data_q <= ctrl_word;
        end
        else
        begin
            addr_q <= data_addr;
            data_q <= i_packed;
        end
    end

    assign o_wr = '{wen: wen_q, waddr: addr_q, wdata: data_q, wlast: last_q};

endmodule

//--- hw/ul_pack_defines.svh
`ifndef UL_PACK_DEFINES_SVH
`define UL_PACK_DEFINES_SVH

// antenna and sample geometry
`define UL_NUM_ANT      4
`define UL_SAMPLE_W     14
`define UL_PACKED_W     16
`define UL_WORD_W       64

// packet layout, 12 groups of 8 beats
`define UL_PKT_BEATS    96
`define UL_GROUP_BEATS  8
`define UL_NUM_GROUPS   12

// CPRI frame buffer address map
`define UL_ADDR_W       7
`define UL_DATA_BASE    7
`define UL_TAIL_BASE    91
`define UL_END_MARK     95

`endif

//--- hw/ul_pack_pkg.sv
`include "ul_pack_defines.svh"

package ul_pack_pkg;

    typedef logic [`UL_SAMPLE_W-1:0] sample_t;

    // antenna 0 in the lowest bits
    typedef sample_t [`UL_NUM_ANT-1:0] ant_samples_t;

    typedef struct packed {
        logic [3:0] ch_type;
        logic       cell_idx;
        logic [6:0] slot_idx;
        logic [3:0] sym_idx;
        logic [8:0] prb_idx;
        logic [3:0] rbg_idx;
    } pkt_hdr_t;

    typedef struct packed {
        pkt_hdr_t                                hdr;
        logic [`UL_NUM_ANT-1:0][`UL_WORD_W-1:0] power;
    } pkt_info_t;

    typedef struct packed {
        logic         vld;
        logic         sop;
        logic         eop;
        ant_samples_t samples;
    } in_beat_t;

    // one bank read travelling down the pipeline
    typedef struct packed {
        logic                  vld;
        logic                  last;
        logic [3:0]            group;
        logic [2:0]            beat;
        logic [`UL_ADDR_W-1:0] raddr;
    } rd_beat_t;

    typedef struct packed {
        logic                  wen;
        logic [`UL_ADDR_W-1:0] waddr;
        logic [`UL_WORD_W-1:0] wdata;
        logic                  wlast;
    } cpri_wr_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_READ
    } seq_state_e;

    typedef enum logic [1:0] {
        CTRL_HDR,
        CTRL_POWER,
        CTRL_RESERVED,
        CTRL_END
    } ctrl_kind_e;

endpackage

//--- hw/ul_package_data.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module ul_package_data
    import ul_pack_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  in_beat_t                              i_beat,
    input  pkt_hdr_t                              i_hdr,
    input  logic [`UL_NUM_ANT-1:0][`UL_WORD_W-1:0] i_power,
    output cpri_wr_t                              o_cpri_wr
);

    logic                  buf_wen;
    logic [`UL_ADDR_W-1:0] buf_waddr;
    ant_samples_t          buf_wdata;
    logic                  buf_commit;
    pkt_info_t             buf_winfo;
    logic [`UL_ADDR_W-1:0] buf_raddr;
    logic                  buf_release;
    ant_samples_t          buf_rdata;
    pkt_info_t             buf_rinfo;
    logic                  buf_rd_avail;
    rd_beat_t              seq_beat;
    rd_beat_t              rep_beat;
    logic [`UL_WORD_W-1:0] rep_packed;

    // --------------------------------------------------
    // capture into the two-bank buffer
    // --------------------------------------------------
    ul_packet_capture u_capture (
        .clk      (clk),
        .rst      (rst),
        .i_beat   (i_beat),
        .i_hdr    (i_hdr),
        .i_power  (i_power),
        .o_wen    (buf_wen),
        .o_waddr  (buf_waddr),
        .o_wdata  (buf_wdata),
        .o_commit (buf_commit),
        .o_info   (buf_winfo)
    );

    ul_sample_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .i_wen      (buf_wen),
        .i_waddr    (buf_waddr),
        .i_wdata    (buf_wdata),
        .i_commit   (buf_commit),
        .i_info     (buf_winfo),
        .i_raddr    (buf_raddr),
        .i_release  (buf_release),
        .o_rdata    (buf_rdata),
        .o_rinfo    (buf_rinfo),
        .o_rd_avail (buf_rd_avail)
    );

    // --------------------------------------------------
    // read back, repack and build the frame writes
    // --------------------------------------------------
    ul_read_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .i_rd_avail (buf_rd_avail),
        .o_raddr    (buf_raddr),
        .o_release  (buf_release),
        .o_beat     (seq_beat)
    );

    ul_sample_repack u_repack (
        .clk      (clk),
        .rst      (rst),
        .i_beat   (seq_beat),
        .i_rdata  (buf_rdata),
        .o_beat   (rep_beat),
        .o_packed (rep_packed)
    );

    ul_frame_assemble u_assemble (
        .clk      (clk),
        .rst      (rst),
        .i_beat   (rep_beat),
        .i_packed (rep_packed),
        .i_info   (buf_rinfo),
        .o_wr     (o_cpri_wr)
    );

endmodule

//--- hw/ul_packet_capture.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module ul_packet_capture
    import ul_pack_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  in_beat_t                              i_beat,
    input  pkt_hdr_t                              i_hdr,
    input  logic [`UL_NUM_ANT-1:0][`UL_WORD_W-1:0] i_power,
    output logic                                  o_wen,
    output logic [`UL_ADDR_W-1:0]                 o_waddr,
    output ant_samples_t                          o_wdata,
    output logic                                  o_commit,
    output pkt_info_t                             o_info
);

    localparam int LAST_BEAT = `UL_PKT_BEATS - 1;

    logic [`UL_ADDR_W-1:0]                 beat_cnt;
    pkt_hdr_t                              hdr_q;
    logic [`UL_NUM_ANT-1:0][`UL_WORD_W-1:0] power_q;

    // --------------------------------------------------
    // beat counter, 0 to 95 then wrap
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_cnt <= '0;
        end
        else if (i_beat.vld)
        begin
            if (beat_cnt == `UL_ADDR_W'(LAST_BEAT))
                beat_cnt <= '0;
            else
                beat_cnt <= beat_cnt + `UL_ADDR_W'(1);
        end
    end

    // header and power only valid with sop
    always_ff @(posedge clk)
    begin
        if (i_beat.vld && i_beat.sop)
        begin
            hdr_q   <= i_hdr;
            power_q <= i_power;
        end
    end

    // write straight through in the input cycle
    assign o_wen    = i_beat.vld;
    assign o_waddr  = beat_cnt;
    assign o_wdata  = i_beat.samples;
    assign o_commit = i_beat.vld && i_beat.eop;
    assign o_info   = '{hdr: hdr_q, power: power_q};

    // packet framing must line up with the beat counter
    a_eop_on_last_beat: assert property (
        @(posedge clk) disable iff (rst)
        i_beat.vld |-> (i_beat.eop == (beat_cnt == `UL_ADDR_W'(LAST_BEAT)))
    );

    a_sop_on_first_beat: assert property (
        @(posedge clk) disable iff (rst)
        (i_beat.vld && i_beat.sop) |-> (beat_cnt == '0)
    );

endmodule

//--- hw/ul_read_sequencer.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module ul_read_sequencer
    import ul_pack_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rd_avail,
    output logic [`UL_ADDR_W-1:0] o_raddr,
    output logic                  o_release,
    output rd_beat_t              o_beat
);

    seq_state_e state;
    logic [2:0] beat_cnt;
    logic [3:0] group_cnt;
    logic       last_rd;

    assign last_rd = (state == SEQ_READ)
                  && (group_cnt == 4'(`UL_NUM_GROUPS - 1))
                  && (beat_cnt == 3'(`UL_GROUP_BEATS - 1));

    // --------------------------------------------------
    // FSM and group/beat counters
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= SEQ_IDLE;
            beat_cnt  <= '0;
            group_cnt <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    if (i_rd_avail)
                        state <= SEQ_READ;
                end
                SEQ_READ:
                begin
                    // beat counter wraps on its own at 8
                    beat_cnt <= beat_cnt + 3'd1;
                    if (beat_cnt == 3'(`UL_GROUP_BEATS - 1))
                        group_cnt <= group_cnt + 4'd1;
                    if (last_rd)
                    begin
                        state     <= SEQ_IDLE;
                        group_cnt <= '0;
                    end
                end
                default:
                    state <= SEQ_IDLE;
            endcase
        end
    end

    // 8 beats per group, so the bank address is just group:beat
    assign o_raddr   = {group_cnt, beat_cnt};
    assign o_release = last_rd;
    assign o_beat    = '{vld:   (state == SEQ_READ),
                         last:  last_rd,
                         group: group_cnt,
                         beat:  beat_cnt,
                         raddr: {group_cnt, beat_cnt}};

    // a bank read lasts 96 cycles and ends with the release
    a_release_ends_read: assert property (
        @(posedge clk) disable iff (rst)
        $rose(state == SEQ_READ) |-> ##95 o_release
    );

endmodule

//--- hw/ul_sample_buffer.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module ul_sample_buffer
    import ul_pack_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_wen,
    input  logic [`UL_ADDR_W-1:0] i_waddr,
    input  ant_samples_t          i_wdata,
    input  logic                  i_commit,
    input  pkt_info_t             i_info,
    input  logic [`UL_ADDR_W-1:0] i_raddr,
    input  logic                  i_release,
    output ant_samples_t          o_rdata,
    output pkt_info_t             o_rinfo,
    output logic                  o_rd_avail
);

    ant_samples_t mem [2][`UL_PKT_BEATS];
    pkt_info_t    info_q [2];
    logic         wr_bank;
    logic         rd_bank;
    logic [1:0]   full;

    // --------------------------------------------------
    // bank pointers and full flags
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            full    <= 2'b00;
        end
        else
        begin
            // release first so a same-cycle commit to the other bank holds
            if (i_release)
            begin
                full[rd_bank] <= 1'b0;
                rd_bank       <= ~rd_bank;
            end
            if (i_commit)
            begin
                full[wr_bank] <= 1'b1;
                wr_bank       <= ~wr_bank;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_wen)
            mem[wr_bank][i_waddr] <= i_wdata;
        if (i_commit)
            info_q[wr_bank] <= i_info;
    end

    // registered read port, one cycle latency
    always_ff @(posedge clk)
    begin
        o_rdata <= mem[rd_bank][i_raddr];
        o_rinfo <= info_q[rd_bank];
    end

    assign o_rd_avail = full[rd_bank];

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        i_commit |-> !(full[0] && full[1])
    );

    // the sequencer must only hand back a bank it was given
    a_release_when_avail: assert property (
        @(posedge clk) disable iff (rst)
        i_release |-> o_rd_avail
    );

endmodule

//--- hw/ul_sample_repack.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module ul_sample_repack
    import ul_pack_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  rd_beat_t              i_beat,
    input  ant_samples_t          i_rdata,
    output rd_beat_t              o_beat,
    output logic [`UL_WORD_W-1:0] o_packed
);

    rd_beat_t                                 beat_d1;
    ant_samples_t                             prev_q;
    logic [`UL_NUM_ANT-1:0][`UL_PACKED_W-1:0] packed_d;
    logic [`UL_WORD_W-1:0]                    packed_q;

    // word k-1 of a group, upper part of prev joined with low bits of cur
    function automatic logic [`UL_PACKED_W-1:0] pack_word(
        input sample_t    prev,
        input sample_t    cur,
        input logic [2:0] k
    );
        logic [2*`UL_SAMPLE_W-1:0] pair;
        logic [4:0]                shift;
        if (k == 3'd0)
            return '0;
        pair  = {cur, prev};
        shift = 5'((`UL_PACKED_W - `UL_SAMPLE_W) * (k - 3'd1));
        return `UL_PACKED_W'(pair >> shift);
    endfunction

    // --------------------------------------------------
    // line the beat up with the buffer read data
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_d1 <= '0;
            o_beat  <= '0;
        end
        else
        begin
            beat_d1 <= i_beat;
            o_beat  <= beat_d1;
        end
    end

    always_comb
    begin
        for (int a = 0; a < `UL_NUM_ANT; a++)
            packed_d[a] = pack_word(prev_q[a], i_rdata[a], beat_d1.beat);
    end

    always_ff @(posedge clk)
    begin
        if (beat_d1.vld)
            prev_q <= i_rdata;
        packed_q <= packed_d;
    end

    assign o_packed = packed_q;

endmodule

//--- sim/tb_ul_package_data.sv
`timescale 1ns/1ps
`include "ul_pack_defines.svh"

module tb_ul_package_data
    import ul_pack_pkg::*;
();

    localparam int          NUM_PKTS = 9;
    localparam logic [31:0] SEED     = 32'h4424_ed5b;

    logic                                   clk;
    logic                                   rst;
    in_beat_t                               beat;
    pkt_hdr_t                               hdr;
    logic [`UL_NUM_ANT-1:0][`UL_WORD_W-1:0] power;
    cpri_wr_t                               cpri_wr;

    logic [31:0]                            rng;
    ant_samples_t                           pkt_samples [`UL_PKT_BEATS];
    pkt_hdr_t                               pkt_hdr;
    logic [`UL_NUM_ANT-1:0][`UL_WORD_W-1:0] pkt_power;
    cpri_wr_t                               exp_q [$];
    int                                     eop_count;
    int                                     wr_count;

    ul_package_data DUT (
        .clk       (clk),
        .rst       (rst),
        .i_beat    (beat),
        .i_hdr     (hdr),
        .i_power   (power),
        .o_cpri_wr (cpri_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input cpri_wr_t got, input cpri_wr_t exp);
        if (got.waddr !== exp.waddr || got.wdata !== exp.wdata)
            fail_run($sformatf(
                "mismatch at time %0t: write %0d addr %0d data %h, expected addr %0d data %h",
                $time, wr_count, got.waddr, got.wdata, exp.waddr, exp.wdata));
    endtask

    task automatic check_last(input cpri_wr_t got, input cpri_wr_t exp);
        if (got.wlast !== exp.wlast)
            fail_run($sformatf("mismatch at time %0t: write %0d wlast %0b, expected %0b",
                               $time, wr_count, got.wlast, exp.wlast));
    endtask

    // --------------------------------------------------
    // stimulus generation and reference model
    // --------------------------------------------------
    task automatic gen_packet();
        for (int b = 0; b < `UL_PKT_BEATS; b++)
        begin
            for (int a = 0; a < `UL_NUM_ANT; a++)
            begin
                rng = xorshift(rng);
                pkt_samples[b][a] = rng[`UL_SAMPLE_W-1:0];
            end
        end
        rng = xorshift(rng);
        pkt_hdr = rng[28:0];
        for (int a = 0; a < `UL_NUM_ANT; a++)
        begin
            rng = xorshift(rng);
            pkt_power[a][63:32] = rng;
            rng = xorshift(rng);
            pkt_power[a][31:0] = rng;
        end
    endtask

    // 96 writes per packet, control word first in each group
    function automatic void queue_expected();
        logic [`UL_NUM_ANT-1:0][8*`UL_SAMPLE_W-1:0] group_bits;
        cpri_wr_t                                   w;
        for (int g = 0; g < `UL_NUM_GROUPS; g++)
        begin
            w.wen   = 1'b1;
            w.wlast = 1'b0;
            // head slots 0 to 6, tail slots 91 to 95
            if (g < 7)
                w.waddr = `UL_ADDR_W'(g);
            else
                w.waddr = `UL_ADDR_W'(84 + g);
            if (g == 0)
                w.wdata = {35'd0, pkt_hdr};
            else if (g <= `UL_NUM_ANT)
                w.wdata = pkt_power[g-1];
            else if (g == `UL_NUM_GROUPS - 1)
                w.wdata = 64'(`UL_END_MARK);
            else
                w.wdata = '0;
            exp_q.push_back(w);

            // eight samples per antenna, sample 0 lowest
            for (int a = 0; a < `UL_NUM_ANT; a++)
                for (int b = 0; b < `UL_GROUP_BEATS; b++)
                    group_bits[a][`UL_SAMPLE_W*b +: `UL_SAMPLE_W] = pkt_samples[8*g+b][a];

            for (int k = 1; k < `UL_GROUP_BEATS; k++)
            begin
                w.waddr = `UL_ADDR_W'(`UL_DATA_BASE + 7*g + k - 1);
                for (int a = 0; a < `UL_NUM_ANT; a++)
                    w.wdata[`UL_PACKED_W*a +: `UL_PACKED_W] =
                        group_bits[a][`UL_PACKED_W*(k-1) +: `UL_PACKED_W];
                w.wlast = (g == `UL_NUM_GROUPS - 1) && (k == `UL_GROUP_BEATS - 1);
                exp_q.push_back(w);
            end
        end
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic send_packet(input bit with_gaps);
        queue_expected();
        for (int b = 0; b < `UL_PKT_BEATS; b++)
        begin
            if (with_gaps)
            begin
                rng = xorshift(rng);
                if (rng[1:0] == 2'b00)
                begin
                    beat.vld = 1'b0;
                    beat.sop = 1'b0;
                    beat.eop = 1'b0;
                    @(posedge clk);
                    #1;
                end
            end
            beat.vld     = 1'b1;
            beat.sop     = (b == 0);
            beat.eop     = (b == `UL_PKT_BEATS - 1);
            beat.samples = pkt_samples[b];
            // header and power are junk outside the sop beat
            hdr   = (b == 0) ? pkt_hdr : ~pkt_hdr;
            power = (b == 0) ? pkt_power : ~pkt_power;
            @(posedge clk);
            if (b == `UL_PKT_BEATS - 1)
                eop_count++;
            #1;
        end
    endtask

    // --------------------------------------------------
    // compare DUT writes against the queue
    // --------------------------------------------------
    initial
    begin : compare_writes
        cpri_wr_t exp;
        forever
        begin
            @(negedge clk);
            if (!rst)
            begin
                if (cpri_wr.wen === 1'b1)
                begin
                    if (exp_q.size() == 0 || wr_count >= eop_count * `UL_PKT_BEATS)
                        fail_run($sformatf(
                            "write at time %0t to addr %0d came before its packet was complete",
                            $time, cpri_wr.waddr));
                    exp = exp_q.pop_front();
                    check_word(cpri_wr, exp);
                    check_last(cpri_wr, exp);
                    wr_count++;
                end
                else if (cpri_wr.wen !== 1'b0 || cpri_wr.wlast !== 1'b0)
                    fail_run($sformatf("wen or wlast not low while idle at time %0t", $time));
            end
        end
    end

    initial
    begin : watchdog
        repeat (NUM_PKTS * `UL_PKT_BEATS * 2 + 200) @(posedge clk);
        fail_run("watchdog timeout, not all packets came out of the DUT");
    end

    initial
    begin : stimulus
        rst       = 1'b1;
        beat      = '0;
        hdr       = '0;
        power     = '0;
        rng       = SEED;
        eop_count = 0;
        wr_count  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // back to back, both banks in use
        for (int p = 0; p < 3; p++)
        begin
            gen_packet();
            send_packet(1'b0);
        end

        // same content with and without vld gaps
        for (int p = 0; p < 3; p++)
        begin
            gen_packet();
            send_packet(1'b1);
            send_packet(1'b0);
        end
        beat = '0;

        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule
